// File: rtl/sfp_send_pkg.sv
// shared widths, board timings and channel 2 state type for the send scheduler blocks
package sfp_send_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int unsigned count_width    = 32;
    localparam int unsigned ram_addr_width = 25;

    // ------------------------------------------------------------------------
    // schedule constants
    // ------------------------------------------------------------------------
    localparam logic [ram_addr_width-1:0] first_ram_addr = 25'd1;
    localparam logic [count_width-1:0]    cmd_pulse_len  = 32'd3;  // enabled cycles per pulse
    localparam logic [count_width-1:0]    wrap_margin    = 32'd10; // counts past period 2

    // board values at 50 MHz
    localparam logic [count_width-1:0] default_send_period_1 = 32'h05F5E100;
    localparam logic [count_width-1:0] default_send_period_2 = 32'h06F5E100;
    localparam logic [count_width-1:0] default_blink_divide  = 32'd25_000_000;

    // channel 2 gets one scheduled send, then echoes data_saved_2
    typedef enum logic
    {
        ch2_first_pending = 1'b0,
        ch2_first_done    = 1'b1
    } ch2_state_t;

endpackage

// File: rtl/send_period_timer.sv
// free-running period counter that decodes the start and stop events of both send slots
`timescale 1ns/100ps

module send_period_timer
#(
    parameter logic [sfp_send_pkg::count_width-1:0] send_period_1 =
        sfp_send_pkg::default_send_period_1,
    parameter logic [sfp_send_pkg::count_width-1:0] send_period_2 =
        sfp_send_pkg::default_send_period_2
)
(
    input  logic clk_50_pll,
    input  logic main_reset,
    input  logic count_enable,

    output logic send_1_start,
    output logic send_1_stop,
    output logic send_2_start,
    output logic send_2_stop
);

    // slot edges and wrap point
    localparam logic [sfp_send_pkg::count_width-1:0] send_1_stop_count =
        send_period_1 + sfp_send_pkg::cmd_pulse_len;
    localparam logic [sfp_send_pkg::count_width-1:0] send_2_stop_count =
        send_period_2 + sfp_send_pkg::cmd_pulse_len;
    localparam logic [sfp_send_pkg::count_width-1:0] wrap_count =
        send_period_2 + sfp_send_pkg::wrap_margin;

    logic [sfp_send_pkg::count_width-1:0] counter_to_send;

    // ------------------------------------------------------------------------
    // period counter, holds while link is down
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            counter_to_send <= '0;
        end
        else if (count_enable)
        begin
            if (counter_to_send == wrap_count)
            begin
                counter_to_send <= '0;  // end of period
            end
            else
            begin
                counter_to_send <= counter_to_send + 1'b1;
            end
        end
    end

    // one strobe per slot edge, only on enabled cycles
    assign send_1_start = count_enable && (counter_to_send == send_period_1);
    assign send_1_stop  = count_enable && (counter_to_send == send_1_stop_count);
    assign send_2_start = count_enable && (counter_to_send == send_period_2);
    assign send_2_stop  = count_enable && (counter_to_send == send_2_stop_count);

endmodule

// File: rtl/send_command_gen.sv
// link-ready gating and the two send command outputs, driven from the period timer events
`timescale 1ns/100ps

module send_command_gen
(
    input  logic                                    clk_50_pll,
    input  logic                                    main_reset,

    input  logic                                    mac_inited,
    input  logic                                    rx_ready,
    input  logic                                    data_saved_2,

    input  logic                                    send_1_start,
    input  logic                                    send_1_stop,
    input  logic                                    send_2_start,
    input  logic                                    send_2_stop,

    output logic                                    count_enable,
    output logic                                    cmd_send_1,
    output logic                                    cmd_send_2,
    output logic [sfp_send_pkg::ram_addr_width-1:0] start_ram_addr_1
);

    sfp_send_pkg::ch2_state_t ch2_state;
    logic                     ch2_slot_active;  // inside the first send slot

    // MAC up and transceiver receive side ready
    assign count_enable = mac_inited & rx_ready;

    // ------------------------------------------------------------------------
    // channel 1, one pulse per period
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            cmd_send_1       <= 1'b0;
            start_ram_addr_1 <= '0;
        end
        else if (count_enable)
        begin
            if (send_1_start)
            begin
                cmd_send_1       <= 1'b1;
                start_ram_addr_1 <= sfp_send_pkg::first_ram_addr;
            end
            else if (send_1_stop)
            begin
                cmd_send_1 <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // channel 2, first scheduled send then data_saved_2 echo
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            ch2_state       <= sfp_send_pkg::ch2_first_pending;
            ch2_slot_active <= 1'b0;
            cmd_send_2      <= 1'b0;
        end
        else if (count_enable)
        begin
            if (ch2_state == sfp_send_pkg::ch2_first_pending && send_2_start)
            begin
                ch2_slot_active <= 1'b1;
                cmd_send_2      <= 1'b1;
            end
            else if (ch2_state == sfp_send_pkg::ch2_first_pending && send_2_stop)
            begin
                ch2_slot_active <= 1'b0;
                cmd_send_2      <= 1'b0;
                ch2_state       <= sfp_send_pkg::ch2_first_done;  // strobes ignored from now
            end
            else if (ch2_slot_active)
            begin
                cmd_send_2 <= 1'b1;  // hold through the slot
            end
            else
            begin
                // receive side saved a packet, send it back
                cmd_send_2 <= data_saved_2;
            end
        end
    end

endmodule

// File: rtl/led_blink_divider.sv
// clock-enable divider that toggles the health LED every blink_divide cycles
`timescale 1ns/100ps

module led_blink_divider
#(
    parameter logic [sfp_send_pkg::count_width-1:0] blink_divide =
        sfp_send_pkg::default_blink_divide
)
(
    input  logic clk_50_pll,
    input  logic main_reset,
    output logic blink_led
);

    localparam logic [sfp_send_pkg::count_width-1:0] last_count = blink_divide - 1'b1;

    logic [sfp_send_pkg::count_width-1:0] blink_count;

    // ------------------------------------------------------------------------
    // divider, counts every cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            blink_count <= '0;
            blink_led   <= 1'b0;
        end
        else if (blink_count == last_count)
        begin
            blink_count <= '0;
            blink_led   <= ~blink_led;  // half blink period done
        end
        else
        begin
            blink_count <= blink_count + 1'b1;
        end
    end

endmodule

// File: rtl/sfp_test_top.sv
// top level of the send scheduler, sets the timing parameters and wires the three blocks
`timescale 1ns/100ps

module sfp_test_top
#(
    parameter logic [sfp_send_pkg::count_width-1:0] send_period_1 =
        sfp_send_pkg::default_send_period_1,
    parameter logic [sfp_send_pkg::count_width-1:0] send_period_2 =
        sfp_send_pkg::default_send_period_2,
    parameter logic [sfp_send_pkg::count_width-1:0] blink_divide  =
        sfp_send_pkg::default_blink_divide
)
(
    input  logic                                    clk_50_pll,
    input  logic                                    main_reset,

    input  logic                                    mac_inited,
    input  logic                                    rx_ready,
    input  logic                                    data_saved_2,

    output logic                                    cmd_send_1,
    output logic                                    cmd_send_2,
    output logic [sfp_send_pkg::ram_addr_width-1:0] start_ram_addr_1,

    output logic                                    blink_led
);

    logic count_enable;   // link ready
    logic send_1_start;
    logic send_1_stop;
    logic send_2_start;
    logic send_2_stop;

    // ------------------------------------------------------------------------
    // period timer
    // ------------------------------------------------------------------------
    send_period_timer
    #(
        .send_period_1 (send_period_1),
        .send_period_2 (send_period_2)
    )
    i_send_period_timer
    (
        .clk_50_pll   (clk_50_pll),
        .main_reset   (main_reset),
        .count_enable (count_enable),
        .send_1_start (send_1_start),
        .send_1_stop  (send_1_stop),
        .send_2_start (send_2_start),
        .send_2_stop  (send_2_stop)
    );

    // ------------------------------------------------------------------------
    // send commands
    // ------------------------------------------------------------------------
    send_command_gen i_send_command_gen
    (
        .clk_50_pll       (clk_50_pll),
        .main_reset       (main_reset),
        .mac_inited       (mac_inited),
        .rx_ready         (rx_ready),
        .data_saved_2     (data_saved_2),
        .send_1_start     (send_1_start),
        .send_1_stop      (send_1_stop),
        .send_2_start     (send_2_start),
        .send_2_stop      (send_2_stop),
        .count_enable     (count_enable),
        .cmd_send_1       (cmd_send_1),
        .cmd_send_2       (cmd_send_2),
        .start_ram_addr_1 (start_ram_addr_1)
    );

    // health blink, runs regardless of link
    led_blink_divider #(.blink_divide (blink_divide)) i_led_blink_divider
    (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset),
        .blink_led  (blink_led)
    );

endmodule

// File: verif/tb_clock_gen.sv
// clock and reset source for the testbench, 40 ns clk_50_pll and main_reset held for 4 cycles
`timescale 1ns/100ps

module tb_clock_gen
(
    output logic clk_50_pll,
    output logic main_reset
);

    initial
    begin
        clk_50_pll = 1'b0;
        forever
        begin
            #20;
            clk_50_pll = ~clk_50_pll;
        end
    end

    initial
    begin
        main_reset = 1'b1;
        repeat (4) @(posedge clk_50_pll);
        #1;
        main_reset = 1'b0;  // just after the 4th edge
    end

endmodule

// File: verif/sfp_send_checker.sv
// testbench checker, runs a reference model of the scheduler on every clock and compares the DUT
`timescale 1ns/100ps

module sfp_send_checker
#(
    parameter logic [sfp_send_pkg::count_width-1:0] send_period_1 = 32'd20,
    parameter logic [sfp_send_pkg::count_width-1:0] send_period_2 = 32'd40,
    parameter logic [sfp_send_pkg::count_width-1:0] blink_divide  = 32'd16
)
(
    input  logic                                    clk_50_pll,
    input  logic                                    main_reset,
    input  logic                                    mac_inited,
    input  logic                                    rx_ready,
    input  logic                                    data_saved_2,
    input  logic                                    cmd_send_1,
    input  logic                                    cmd_send_2,
    input  logic [sfp_send_pkg::ram_addr_width-1:0] start_ram_addr_1,
    input  logic                                    blink_led,
    output int                                      error_count
);

    // enabled cycles in one schedule period
    localparam int unsigned period_len = send_period_2 + sfp_send_pkg::wrap_margin + 1;
    localparam int unsigned pulse_len  = sfp_send_pkg::cmd_pulse_len;

    int unsigned                             enabled_total;  // enabled edges since reset
    int unsigned                             cycle_total;
    logic                                    exp_cmd_send_1;
    logic                                    exp_cmd_send_2;
    logic                                    exp_blink;
    logic [sfp_send_pkg::ram_addr_width-1:0] exp_start_addr;
    sfp_send_pkg::ch2_state_t                exp_state;

    logic                                    last_cmd_send_1;
    logic                                    last_blink;
    int unsigned                             cmd_1_rise_at;
    int unsigned                             cmd_1_rises;
    int unsigned                             blink_toggle_at;
    int unsigned                             blink_toggles;

    // ------------------------------------------------------------------------
    // reference functions, pos is the enabled-cycle position in the period
    // ------------------------------------------------------------------------
    function automatic logic ref_cmd_send_1(input int unsigned pos, input logic prev);
        if (pos == send_period_1)
            return 1'b1;
        if (pos == send_period_1 + pulse_len)
            return 1'b0;
        return prev;
    endfunction

    function automatic logic [sfp_send_pkg::ram_addr_width-1:0] ref_start_addr(
        input int unsigned pos, input logic [sfp_send_pkg::ram_addr_width-1:0] prev);
        return (pos == send_period_1) ? sfp_send_pkg::first_ram_addr : prev;
    endfunction

    function automatic logic ref_cmd_send_2(input int unsigned pos,
        input sfp_send_pkg::ch2_state_t state, input logic data_saved);
        if (state == sfp_send_pkg::ch2_first_pending)
        begin
            if (pos >= send_period_2 && pos < send_period_2 + pulse_len)
                return 1'b1;   // first scheduled send
            if (pos == send_period_2 + pulse_len)
                return 1'b0;
        end
        return data_saved;
    endfunction

    function automatic sfp_send_pkg::ch2_state_t ref_ch2_state(input int unsigned pos,
        input sfp_send_pkg::ch2_state_t state);
        if (pos == send_period_2 + pulse_len)
            return sfp_send_pkg::ch2_first_done;
        return state;
    endfunction

    // edges is the number of clock edges after the coming one
    function automatic logic ref_blink(input int unsigned edges, input logic prev);
        return (edges % blink_divide == 0) ? ~prev : prev;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------------------
    // compare at the falling edge, then step the model for the next rising edge
    // ------------------------------------------------------------------------
    initial error_count = 0;

    always @(negedge clk_50_pll)
    begin
        if (main_reset)
        begin
            enabled_total   = 0;
            cycle_total     = 0;
            exp_cmd_send_1  = 1'b0;
            exp_cmd_send_2  = 1'b0;
            exp_blink       = 1'b0;
            exp_start_addr  = '0;
            exp_state       = sfp_send_pkg::ch2_first_pending;
            last_cmd_send_1 = 1'b0;
            last_blink      = 1'b0;
            cmd_1_rises     = 0;
            blink_toggles   = 0;
        end
        else
        begin
            compare_value("cmd_send_1", exp_cmd_send_1, cmd_send_1);
            compare_value("cmd_send_2", exp_cmd_send_2, cmd_send_2);
            compare_value("start_ram_addr_1", exp_start_addr, start_ram_addr_1);
            compare_value("blink_led", exp_blink, blink_led);

            if (cmd_send_1 === 1'b1 && last_cmd_send_1 === 1'b0)
            begin
                if (cmd_1_rises > 0)
                    compare_value("cmd_send_1 rise interval", period_len,
                                  enabled_total - cmd_1_rise_at);
                cmd_1_rise_at = enabled_total;
                cmd_1_rises++;
            end
            if (cmd_send_1 === 1'b0 && last_cmd_send_1 === 1'b1)
                compare_value("cmd_send_1 pulse width", pulse_len, enabled_total - cmd_1_rise_at);
            if (blink_led !== last_blink)
            begin
                if (blink_toggles > 0)
                    compare_value("blink_led toggle interval", blink_divide,
                                  cycle_total - blink_toggle_at);
                blink_toggle_at = cycle_total;
                blink_toggles++;
            end
            last_cmd_send_1 = cmd_send_1;
            last_blink      = blink_led;

            // inputs are stable here until after the next rising edge
            if (mac_inited === 1'b1 && rx_ready === 1'b1)
            begin
                exp_cmd_send_1 = ref_cmd_send_1(enabled_total % period_len, exp_cmd_send_1);
                exp_start_addr = ref_start_addr(enabled_total % period_len, exp_start_addr);
                exp_cmd_send_2 = ref_cmd_send_2(enabled_total % period_len, exp_state,
                                                data_saved_2);
                exp_state      = ref_ch2_state(enabled_total % period_len, exp_state);
                enabled_total++;
            end
            cycle_total++;
            exp_blink = ref_blink(cycle_total, exp_blink);
        end
    end

endmodule

// File: verif/tb_sfp_test_top.sv
// testbench top, drives link-ready and data_saved_2 into the scheduler and runs the test sequence
`timescale 1ns/100ps

module tb_sfp_test_top;

    localparam int sel_cmd_send_1 = 0;
    localparam int sel_cmd_send_2 = 1;
    localparam int sel_main_reset = 2;

    logic        clk_50_pll;
    logic        main_reset;
    logic        mac_inited;
    logic        rx_ready;
    logic        data_saved_2;
    logic        cmd_send_1;
    logic        cmd_send_2;
    logic        blink_led;
    logic [sfp_send_pkg::ram_addr_width-1:0] start_ram_addr_1;

    int          error_count;
    int          timeout_count;
    int          failures_before;
    int          tests_passed;
    int          tests_failed;
    int          round;
    int unsigned seed;

    tb_clock_gen i_tb_clock_gen (.clk_50_pll (clk_50_pll), .main_reset (main_reset));

    sfp_test_top #(.send_period_1 (32'd20), .send_period_2 (32'd40), .blink_divide (32'd16))
    i_sfp_test_top
    (
        .clk_50_pll       (clk_50_pll),
        .main_reset       (main_reset),
        .mac_inited       (mac_inited),
        .rx_ready         (rx_ready),
        .data_saved_2     (data_saved_2),
        .cmd_send_1       (cmd_send_1),
        .cmd_send_2       (cmd_send_2),
        .start_ram_addr_1 (start_ram_addr_1),
        .blink_led        (blink_led)
    );

    sfp_send_checker #(.send_period_1 (32'd20), .send_period_2 (32'd40), .blink_divide (32'd16))
    i_sfp_send_checker
    (
        .clk_50_pll       (clk_50_pll),
        .main_reset       (main_reset),
        .mac_inited       (mac_inited),
        .rx_ready         (rx_ready),
        .data_saved_2     (data_saved_2),
        .cmd_send_1       (cmd_send_1),
        .cmd_send_2       (cmd_send_2),
        .start_ram_addr_1 (start_ram_addr_1),
        .blink_led        (blink_led),
        .error_count      (error_count)
    );

    function automatic logic watched_level(input int sel);
        case (sel)
            sel_cmd_send_1: return cmd_send_1;
            sel_cmd_send_2: return cmd_send_2;
            default:        return main_reset;
        endcase
    endfunction

    // steps one clock at a time, 2 ns past the edge
    task automatic wait_for_level(input int sel, input logic level, input string what);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 2000)
        begin
            @(posedge clk_50_pll);
            #2;
            cycles++;
            seen = (watched_level(sel) === level);
        end
        if (!seen)
        begin
            $display("timeout: %s did not happen within 2000 cycles", what);
            timeout_count++;
        end
    endtask

    task automatic run_cycles(input int count);
        repeat (count)
        begin
            @(posedge clk_50_pll);
            #2;
        end
    endtask

    task automatic finish_test(input string name);
        int failures;
        failures = error_count + timeout_count - failures_before;
        if (failures == 0)
        begin
            $display("test %s: pass", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: failed with %0d errors", name, failures);
            tests_failed++;
        end
        failures_before = error_count + timeout_count;
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial
    begin
        mac_inited      = 1'b0;
        rx_ready        = 1'b0;
        data_saved_2    = 1'b0;
        timeout_count   = 0;
        failures_before = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        seed            = 32'h682f_03d3;
        void'($urandom(seed));

        wait_for_level(sel_main_reset, 1'b0, "release of main_reset");
        mac_inited = 1'b1;
        rx_ready   = 1'b1;
        wait_for_level(sel_cmd_send_1, 1'b1, "first rise of cmd_send_1");
        wait_for_level(sel_cmd_send_1, 1'b0, "fall of cmd_send_1");
        finish_test("reset and send 1 period");

        // data_saved_2 stays low, so only the scheduled send shows
        wait_for_level(sel_cmd_send_2, 1'b1, "first send on cmd_send_2");
        wait_for_level(sel_cmd_send_2, 1'b0, "end of first send on cmd_send_2");
        wait_for_level(sel_cmd_send_1, 1'b1, "second period cmd_send_1");
        wait_for_level(sel_cmd_send_1, 1'b0, "fall of cmd_send_1");
        wait_for_level(sel_cmd_send_1, 1'b1, "third period cmd_send_1");
        finish_test("first send on channel 2");

        for (round = 0; round < 10; round++)
        begin
            run_cycles(5 + $urandom % 56);
            if ($urandom % 2)
                mac_inited = 1'b0;
            else
                rx_ready = 1'b0;
            run_cycles(1 + $urandom % 40);
            mac_inited = 1'b1;
            rx_ready   = 1'b1;
        end
        finish_test("link gating");

        repeat (300)
        begin
            data_saved_2 = $urandom % 2;
            mac_inited   = ($urandom % 6) != 0;  // short random gaps
            run_cycles(1);
        end
        mac_inited   = 1'b1;
        data_saved_2 = 1'b0;
        finish_test("echo of data_saved_2");

        wait_for_level(sel_cmd_send_1, 1'b1, "cmd_send_1 for start address");
        wait_for_level(sel_cmd_send_1, 1'b0, "fall of cmd_send_1");
        wait_for_level(sel_cmd_send_1, 1'b1, "cmd_send_1 for start address");
        finish_test("start address");

        rx_ready = 1'b0;
        run_cycles(100);
        rx_ready = 1'b1;
        run_cycles(40);
        finish_test("blink led");

        $display("tests passed %0d failed %0d, mismatches %0d, timeouts %0d",
                 tests_passed, tests_failed, error_count, timeout_count);
        if (tests_failed == 0 && error_count + timeout_count == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/sfp_send_pkg.sv
rtl/send_period_timer.sv
rtl/send_command_gen.sv
rtl/led_blink_divider.sv
rtl/sfp_test_top.sv
verif/tb_clock_gen.sv
verif/sfp_send_checker.sv
verif/tb_sfp_test_top.sv

// File: Bender.yml
package:
  name: sfp_send_scheduler

sources:
  # design, package first
  - rtl/sfp_send_pkg.sv
  - rtl/send_period_timer.sv
  - rtl/send_command_gen.sv
  - rtl/led_blink_divider.sv
  - rtl/sfp_test_top.sv

  # testbench
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/sfp_send_checker.sv
      - verif/tb_sfp_test_top.sv
